//--- eboxWordPkg.sv
// Word layout for the reduced EBOX data path. Bit 0 is the sign and most significant bit,
// as in the PDP-10 numbering; fast memory is 8 blocks of 16 words.
package eboxWordPkg;

  // Data word and halfword sizes
  localparam int wordWidth = 36;
  localparam int halfWidth = 18;

  // One 36-bit word, used whole by the adder and in halves by AR, EBUS and FM
  typedef union packed {
    logic [0:wordWidth-1] full;
    struct packed {
      // Bits 0 to 17
      logic [0:halfWidth-1] left;
      // Bits 18 to 35
      logic [0:halfWidth-1] right;
    } half;
  } tuWord;

  // Fast memory geometry
  localparam int fmBlockWidth = 3;
  localparam int fmAdrWidth   = 4;

  // Block number sits above the word address in the index
  localparam int fmIndexWidth = fmBlockWidth + fmAdrWidth;
  localparam int fmDepth      = 1 << fmIndexWidth;

endpackage

//--- eboxCramPkg.sv
// Microword field widths and encodings. Only the fields kept in this
// reduced data path are defined; no ADX, ARX or diagnostic fields.
package eboxCramPkg;

  localparam int adFuncWidth = 3;
  localparam int selWidth    = 2;
  localparam int mqOpWidth   = 2;

  // AD function
  localparam logic [0:adFuncWidth-1] adAdd    = 3'd0;
  // A minus B
  localparam logic [0:adFuncWidth-1] adSub    = 3'd1;
  localparam logic [0:adFuncWidth-1] adAnd    = 3'd2;
  localparam logic [0:adFuncWidth-1] adOr     = 3'd3;
  localparam logic [0:adFuncWidth-1] adXor    = 3'd4;
  localparam logic [0:adFuncWidth-1] adPassA  = 3'd5;
  localparam logic [0:adFuncWidth-1] adPassB  = 3'd6;
  // A plus 1
  localparam logic [0:adFuncWidth-1] adAddOne = 3'd7;

  // ADA source
  localparam logic [0:selWidth-1] adaAr   = 2'd0;
  localparam logic [0:selWidth-1] adaMq   = 2'd1;
  localparam logic [0:selWidth-1] adaPc   = 2'd2;
  localparam logic [0:selWidth-1] adaZero = 2'd3;

  // ADB source; shifted forms fill with zeros on the right
  localparam logic [0:selWidth-1] adbFm   = 2'd0;
  localparam logic [0:selWidth-1] adbBrX2 = 2'd1;
  localparam logic [0:selWidth-1] adbBr   = 2'd2;
  localparam logic [0:selWidth-1] adbArX4 = 2'd3;

  // AR load source
  localparam logic [0:selWidth-1] arFromAd    = 2'd0;
  localparam logic [0:selWidth-1] arFromCache = 2'd1;
  localparam logic [0:selWidth-1] arFromEbus  = 2'd2;
  localparam logic [0:selWidth-1] arFromSh    = 2'd3;

  // MQ universal shift register function
  localparam logic [0:mqOpWidth-1] mqLoad = 2'b00;
  localparam logic [0:mqOpWidth-1] mqShl  = 2'b01;
  localparam logic [0:mqOpWidth-1] mqShr  = 2'b10;
  localparam logic [0:mqOpWidth-1] mqHold = 2'b11;

  // Step sequencer states
  localparam int stepStateWidth = 2;
  localparam logic [0:stepStateWidth-1] stepIdle = 2'd0;
  localparam logic [0:stepStateWidth-1] stepExec = 2'd1;
  localparam logic [0:stepStateWidth-1] stepAck  = 2'd2;

endpackage

//--- microStepControl.sv
// Four-phase req/ack step sequencer. The requester must hold the microword
// steady from req high until ack is seen high.
`timescale 1ns/10ps

module microStepControl (
  input  logic eboxClk,
  input  logic rstN,
  input  logic req,
  output logic ack,
  output logic exec
);

  logic [0:eboxCramPkg::stepStateWidth-1] state;

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      state <= eboxCramPkg::stepIdle;
      ack   <= 1'b0;
    end else begin
      case (state)
        eboxCramPkg::stepIdle: begin
          if (req) begin
            state <= eboxCramPkg::stepExec;
          end
        end
        // Data path registers load at the end of this cycle
        eboxCramPkg::stepExec: begin
          state <= eboxCramPkg::stepAck;
        end
        eboxCramPkg::stepAck: begin
          if (!ack) begin
            ack <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;
            state <= eboxCramPkg::stepIdle;
          end
        end
        default: begin
          state <= eboxCramPkg::stepIdle;
        end
      endcase
    end
  end

  assign exec = (state == eboxCramPkg::stepExec);

  // One register update per accepted request
  execSingleCycle: assert property (@(posedge eboxClk) disable iff (!rstN) exec |=> !exec);

  // Result is never acknowledged while it is still being produced
  ackExecExclusive: assert property (@(posedge eboxClk) disable iff (!rstN) !(ack && exec));

endmodule

//--- edpAdder.sv
// Behavioral AD unit, no look-ahead carry chips. Carry and overflow are
// meaningful only for add, subtract and add-one; logic functions give zero.
`timescale 1ns/10ps

module edpAdder (
  input  eboxWordPkg::tuWord                  ar,
  input  eboxWordPkg::tuWord                  mq,
  input  eboxWordPkg::tuWord                  br,
  input  eboxWordPkg::tuWord                  fm,
  input  eboxWordPkg::tuWord                  pc,
  input  logic [0:eboxCramPkg::selWidth-1]    adaSel,
  input  logic [0:eboxCramPkg::selWidth-1]    adbSel,
  input  logic [0:eboxCramPkg::adFuncWidth-1] adFunc,
  output eboxWordPkg::tuWord                  ad,
  output logic                                adCarry,
  output logic                                adOverflow
);

  logic [0:eboxWordPkg::wordWidth-1]  adaMux;
  logic [0:eboxWordPkg::wordWidth-1]  adbMux;
  logic [0:eboxWordPkg::wordWidth-1]  bOperand;
  logic                               carryIn;
  logic                               arith;
  // Bit -1 holds the carry out of bit 0
  logic [-1:eboxWordPkg::wordWidth-1] sum;

  always_comb begin
    case (adaSel)
      eboxCramPkg::adaAr: adaMux = ar.full;
      eboxCramPkg::adaMq: adaMux = mq.full;
      eboxCramPkg::adaPc: adaMux = pc.full;
      default:            adaMux = '0;
    endcase

    case (adbSel)
      eboxCramPkg::adbFm:   adbMux = fm.full;
      eboxCramPkg::adbBrX2: adbMux = {br.full[1:eboxWordPkg::wordWidth-1], 1'b0};
      eboxCramPkg::adbBr:   adbMux = br.full;
      default:              adbMux = {ar.full[2:eboxWordPkg::wordWidth-1], 2'b00};
    endcase
  end

  always_comb begin
    bOperand = adbMux;
    carryIn  = 1'b0;
    arith    = 1'b1;
    case (adFunc)
      eboxCramPkg::adAdd: bOperand = adbMux;
      // Two's complement subtract as A + ~B + 1
      eboxCramPkg::adSub: begin
        bOperand = ~adbMux;
        carryIn  = 1'b1;
      end
      eboxCramPkg::adAddOne: begin
        bOperand = '0;
        carryIn  = 1'b1;
      end
      default: arith = 1'b0;
    endcase

    sum = {1'b0, adaMux} + {1'b0, bOperand} + {{eboxWordPkg::wordWidth{1'b0}}, carryIn};

    case (adFunc)
      eboxCramPkg::adAnd:   ad.full = adaMux & adbMux;
      eboxCramPkg::adOr:    ad.full = adaMux | adbMux;
      eboxCramPkg::adXor:   ad.full = adaMux ^ adbMux;
      eboxCramPkg::adPassA: ad.full = adaMux;
      eboxCramPkg::adPassB: ad.full = adbMux;
      default:              ad.full = sum[0:eboxWordPkg::wordWidth-1];
    endcase

    adCarry = arith & sum[-1];
    // Signs agree going in but the result sign differs
    adOverflow = arith & (adaMux[0] == bOperand[0]) & (sum[0] != adaMux[0]);
  end

endmodule

//--- edpRegisters.sv
// AR, BR, MQ and the EBUS output register. All loads happen only at the
// edge that ends an exec cycle; AR halves clear in preference to loading.
`timescale 1ns/10ps

module edpRegisters (
  input  logic                              eboxClk,
  input  logic                              rstN,
  input  logic                              exec,
  input  eboxWordPkg::tuWord                ad,
  input  eboxWordPkg::tuWord                cacheData,
  input  eboxWordPkg::tuWord                ebusIn,
  input  eboxWordPkg::tuWord                shiftIn,
  input  logic                              adCarry,
  input  logic [0:eboxCramPkg::selWidth-1]  arSel,
  input  logic                              arLeftLoad,
  input  logic                              arRightLoad,
  input  logic                              arLeftClr,
  input  logic                              arRightClr,
  input  logic                              brLoad,
  input  logic [0:eboxCramPkg::mqOpWidth-1] mqOp,
  input  logic                              ebusLeftEn,
  input  logic                              ebusRightEn,
  output eboxWordPkg::tuWord                ar,
  output eboxWordPkg::tuWord                br,
  output eboxWordPkg::tuWord                mq,
  output eboxWordPkg::tuWord                ebus,
  output logic                              ebusDrive
);

  eboxWordPkg::tuWord arSrc;

  // AR source mux, shared by both halves
  always_comb begin
    case (arSel)
      eboxCramPkg::arFromAd:    arSrc = ad;
      eboxCramPkg::arFromCache: arSrc = cacheData;
      eboxCramPkg::arFromEbus:  arSrc = ebusIn;
      default:                  arSrc = shiftIn;
    endcase
  end

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ar <= '0;
    end else if (exec) begin
      if (arLeftClr) begin
        ar.half.left <= '0;
      end else if (arLeftLoad) begin
        ar.half.left <= arSrc.half.left;
      end

      if (arRightClr) begin
        ar.half.right <= '0;
      end else if (arRightLoad) begin
        ar.half.right <= arSrc.half.right;
      end
    end
  end

  // BR takes AR as it was before this step
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      br <= '0;
    end else if (exec && brLoad) begin
      br <= ar;
    end
  end

  // MQ as a universal shift register
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      mq <= '0;
    end else if (exec) begin
      case (mqOp)
        eboxCramPkg::mqLoad: mq.full <= ad.full;
        eboxCramPkg::mqShl:  mq.full <= {mq.full[1:eboxWordPkg::wordWidth-1], adCarry};
        eboxCramPkg::mqShr:  mq.full <= {mq.full[0], mq.full[0:eboxWordPkg::wordWidth-2]};
        default:             mq.full <= mq.full;
      endcase
    end
  end

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ebus      <= '0;
      ebusDrive <= 1'b0;
    end else if (exec) begin
      if (ebusLeftEn) begin
        ebus.half.left <= ad.half.left;
      end
      if (ebusRightEn) begin
        ebus.half.right <= ad.half.right;
      end
      // Drive flag reflects only the latest step
      ebusDrive <= ebusLeftEn | ebusRightEn;
    end
  end

  // Stays clean as long as every step's inputs are driven
  arMqKnown: assert property (@(posedge eboxClk) disable iff (!rstN)
    !$isunknown({ar.full, mq.full}));

endmodule

//--- fastMemory.sv
// 128-word fast memory written from AR by halfword, read asynchronously.
// No reset; contents are undefined until written.
`timescale 1ns/10ps

module fastMemory (
  input  logic                                  eboxClk,
  input  logic                                  exec,
  input  logic [0:eboxWordPkg::fmBlockWidth-1] fmBlock,
  input  logic [0:eboxWordPkg::fmAdrWidth-1]   fmAdr,
  input  eboxWordPkg::tuWord                    writeData,
  input  logic                                  writeLeft,
  input  logic                                  writeRight,
  output eboxWordPkg::tuWord                    readData
);

  eboxWordPkg::tuWord mem [0:eboxWordPkg::fmDepth-1];

  logic [0:eboxWordPkg::fmIndexWidth-1] fmIndex;

  // Block selects the upper index bits
  assign fmIndex = {fmBlock, fmAdr};

  always_ff @(posedge eboxClk) begin
    if (exec) begin
      if (writeLeft) begin
        mem[fmIndex].half.left <= writeData.half.left;
      end
      if (writeRight) begin
        mem[fmIndex].half.right <= writeData.half.right;
      end
    end
  end

  assign readData = mem[fmIndex];

  // Address comes from the requester and must be settled by the write edge
  fmWriteAddrKnown: assert property (@(posedge eboxClk)
    (exec && (writeLeft || writeRight)) |-> !$isunknown(fmIndex));

endmodule

//--- eboxDataPath.sv
// Reduced EBOX data path top. One microword per four-phase req/ack step;
// fields and data inputs must stay steady while req is high.
`timescale 1ns/10ps

module eboxDataPath (
  input  logic                                  eboxClk,
  input  logic                                  rstN,
  input  logic                                  req,
  output logic                                  ack,
  input  logic [0:eboxCramPkg::adFuncWidth-1]   adFunc,
  input  logic [0:eboxCramPkg::selWidth-1]      adaSel,
  input  logic [0:eboxCramPkg::selWidth-1]      adbSel,
  input  logic [0:eboxCramPkg::selWidth-1]      arSel,
  input  logic                                  arLeftLoad,
  input  logic                                  arRightLoad,
  input  logic                                  arLeftClr,
  input  logic                                  arRightClr,
  input  logic                                  brLoad,
  input  logic [0:eboxCramPkg::mqOpWidth-1]     mqOp,
  input  logic [0:eboxWordPkg::fmBlockWidth-1] fmBlock,
  input  logic [0:eboxWordPkg::fmAdrWidth-1]   fmAdr,
  input  logic                                  fmWriteLeft,
  input  logic                                  fmWriteRight,
  input  logic                                  ebusLeftEn,
  input  logic                                  ebusRightEn,
  input  eboxWordPkg::tuWord                    cacheData,
  input  eboxWordPkg::tuWord                    ebusIn,
  input  eboxWordPkg::tuWord                    shiftIn,
  input  eboxWordPkg::tuWord                    pc,
  output eboxWordPkg::tuWord                    ar,
  output eboxWordPkg::tuWord                    br,
  output eboxWordPkg::tuWord                    mq,
  output eboxWordPkg::tuWord                    fm,
  output eboxWordPkg::tuWord                    ad,
  output logic                                  adCarry,
  output logic                                  adOverflow,
  output eboxWordPkg::tuWord                    ebus,
  output logic                                  ebusDrive
);

  logic exec;

  microStepControl i_microStepControl (
    .eboxClk (eboxClk),
    .rstN    (rstN),
    .req     (req),
    .ack     (ack),
    .exec    (exec)
  );

  edpAdder i_edpAdder (
    .ar         (ar),
    .mq         (mq),
    .br         (br),
    .fm         (fm),
    .pc         (pc),
    .adaSel     (adaSel),
    .adbSel     (adbSel),
    .adFunc     (adFunc),
    .ad         (ad),
    .adCarry    (adCarry),
    .adOverflow (adOverflow)
  );

  edpRegisters i_edpRegisters (
    .eboxClk     (eboxClk),
    .rstN        (rstN),
    .exec        (exec),
    .ad          (ad),
    .cacheData   (cacheData),
    .ebusIn      (ebusIn),
    .shiftIn     (shiftIn),
    .adCarry     (adCarry),
    .arSel       (arSel),
    .arLeftLoad  (arLeftLoad),
    .arRightLoad (arRightLoad),
    .arLeftClr   (arLeftClr),
    .arRightClr  (arRightClr),
    .brLoad      (brLoad),
    .mqOp        (mqOp),
    .ebusLeftEn  (ebusLeftEn),
    .ebusRightEn (ebusRightEn),
    .ar          (ar),
    .br          (br),
    .mq          (mq),
    .ebus        (ebus),
    .ebusDrive   (ebusDrive)
  );

  // FM is always written from AR
  fastMemory i_fastMemory (
    .eboxClk    (eboxClk),
    .exec       (exec),
    .fmBlock    (fmBlock),
    .fmAdr      (fmAdr),
    .writeData  (ar),
    .writeLeft  (fmWriteLeft),
    .writeRight (fmWriteRight),
    .readData   (fm)
  );

endmodule

//--- eboxDataPathTb.sv
// Self-checking testbench for the reduced EBOX data path. FM is filled before any step
// selects it on ADB, because its contents are undefined after reset.
`timescale 1ns/10ps

module eboxDataPathTb;

  // Cycles allowed for any single wait
  localparam int stepTimeout = 20;

  logic                                  eboxClk;
  logic                                  rstN;
  logic                                  req;
  logic                                  ack;
  logic [0:eboxCramPkg::adFuncWidth-1]   adFunc;
  logic [0:eboxCramPkg::selWidth-1]      adaSel;
  logic [0:eboxCramPkg::selWidth-1]      adbSel;
  logic [0:eboxCramPkg::selWidth-1]      arSel;
  logic                                  arLeftLoad;
  logic                                  arRightLoad;
  logic                                  arLeftClr;
  logic                                  arRightClr;
  logic                                  brLoad;
  logic [0:eboxCramPkg::mqOpWidth-1]     mqOp;
  logic [0:eboxWordPkg::fmBlockWidth-1] fmBlock;
  logic [0:eboxWordPkg::fmAdrWidth-1]   fmAdr;
  logic                                  fmWriteLeft;
  logic                                  fmWriteRight;
  logic                                  ebusLeftEn;
  logic                                  ebusRightEn;
  eboxWordPkg::tuWord                    cacheData;
  eboxWordPkg::tuWord                    ebusIn;
  eboxWordPkg::tuWord                    shiftIn;
  eboxWordPkg::tuWord                    pc;
  eboxWordPkg::tuWord                    ar;
  eboxWordPkg::tuWord                    br;
  eboxWordPkg::tuWord                    mq;
  eboxWordPkg::tuWord                    fm;
  eboxWordPkg::tuWord                    ad;
  logic                                  adCarry;
  logic                                  adOverflow;
  eboxWordPkg::tuWord                    ebus;
  logic                                  ebusDrive;

  // Model of the architectural state
  eboxWordPkg::tuWord mAr;
  eboxWordPkg::tuWord mBr;
  eboxWordPkg::tuWord mMq;
  eboxWordPkg::tuWord mEbus;
  logic               mDrive;
  eboxWordPkg::tuWord mFm [0:eboxWordPkg::fmDepth-1];
  logic               mFmValid [0:eboxWordPkg::fmDepth-1];
  eboxWordPkg::tuWord expAd;
  logic               expCarry;
  logic               expOvf;

  logic [31:0] lfsrState;
  logic        wantAck;
  logic        hung;
  int          checkRequests = 0;
  int          checksDone = 0;
  int          stepCount = 0;
  int          handshakeErrors = 0;
  int          compareErrors = 0;
  int          checkCount = 0;

  eboxDataPath i_eboxDataPath (.*);

  initial begin
    eboxClk = 1'b0;
    forever #2 eboxClk = ~eboxClk;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic logic [35:0] drawBits(input int count);
    logic [35:0] value;
    int k;
    value = '0;
    for (k = 0; k < count; k++) begin
      value = {value[34:0], lfsrState[0]};
      lfsrState = nextLfsr(lfsrState);
    end
    return value;
  endfunction

  // AD result from the model registers and the fields now on the DUT inputs
  function automatic void evalAd(output eboxWordPkg::tuWord res, output logic carry,
                                 output logic ovf);
    logic [0:35] a;
    logic [0:35] b;
    logic [36:0] wide;
    case (adaSel)
      eboxCramPkg::adaAr: a = mAr.full;
      eboxCramPkg::adaMq: a = mMq.full;
      eboxCramPkg::adaPc: a = pc.full;
      default:            a = '0;
    endcase
    case (adbSel)
      eboxCramPkg::adbFm:   b = mFm[{fmBlock, fmAdr}].full;
      eboxCramPkg::adbBrX2: b = mBr.full << 1;
      eboxCramPkg::adbBr:   b = mBr.full;
      default:              b = mAr.full << 2;
    endcase
    carry = 1'b0;
    ovf   = 1'b0;
    case (adFunc)
      eboxCramPkg::adAdd: begin
        wide     = {1'b0, a} + {1'b0, b};
        res.full = wide[35:0];
        carry    = wide[36];
        ovf      = (a[0] == b[0]) && (res.full[0] != a[0]);
      end
      // No borrow means carry out
      eboxCramPkg::adSub: begin
        res.full = a - b;
        carry    = (a >= b);
        ovf      = (a[0] != b[0]) && (res.full[0] != a[0]);
      end
      eboxCramPkg::adAnd:   res.full = a & b;
      eboxCramPkg::adOr:    res.full = a | b;
      eboxCramPkg::adXor:   res.full = a ^ b;
      eboxCramPkg::adPassA: res.full = a;
      eboxCramPkg::adPassB: res.full = b;
      default: begin
        wide     = {1'b0, a} + 37'd1;
        res.full = wide[35:0];
        carry    = wide[36];
        ovf      = !a[0] && res.full[0];
      end
    endcase
  endfunction

  // Advances the model by one microinstruction and sets the expected outputs
  function automatic void refStep();
    eboxWordPkg::tuWord preAd;
    eboxWordPkg::tuWord src;
    eboxWordPkg::tuWord oldAr;
    logic preCarry;
    logic preOvf;
    logic [eboxWordPkg::fmIndexWidth-1:0] idx;
    evalAd(preAd, preCarry, preOvf);
    idx   = {fmBlock, fmAdr};
    oldAr = mAr;
    case (arSel)
      eboxCramPkg::arFromAd:    src = preAd;
      eboxCramPkg::arFromCache: src = cacheData;
      eboxCramPkg::arFromEbus:  src = ebusIn;
      default:                  src = shiftIn;
    endcase
    if (arLeftClr) begin
      mAr.half.left = '0;
    end else if (arLeftLoad) begin
      mAr.half.left = src.half.left;
    end
    if (arRightClr) begin
      mAr.half.right = '0;
    end else if (arRightLoad) begin
      mAr.half.right = src.half.right;
    end
    if (brLoad) begin
      mBr = oldAr;
    end
    case (mqOp)
      eboxCramPkg::mqLoad: mMq = preAd;
      eboxCramPkg::mqShl:  mMq.full = (mMq.full << 1) | {35'd0, preCarry};
      eboxCramPkg::mqShr:  mMq.full = $signed(mMq.full) >>> 1;
      default:             mMq = mMq;
    endcase
    if (ebusLeftEn) begin
      mEbus.half.left = preAd.half.left;
    end
    if (ebusRightEn) begin
      mEbus.half.right = preAd.half.right;
    end
    mDrive = ebusLeftEn | ebusRightEn;
    // FM is written from AR as it stood before the step
    if (fmWriteLeft) begin
      mFm[idx].half.left = oldAr.half.left;
    end
    if (fmWriteRight) begin
      mFm[idx].half.right = oldAr.half.right;
    end
    if (fmWriteLeft && fmWriteRight) begin
      mFmValid[idx] = 1'b1;
    end
    // While ack is high, AD reflects the updated registers
    evalAd(expAd, expCarry, expOvf);
  endfunction

  task automatic checkWord(input string name, input eboxWordPkg::tuWord got,
                           input eboxWordPkg::tuWord expected);
    checkCount++;
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got.full,
               expected.full);
      compareErrors++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic expected);
    checkCount++;
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, expected);
      compareErrors++;
    end
  endtask

  // Compare process, once per requested check, on a falling edge
  always @(negedge eboxClk) begin
    if (checksDone != checkRequests && ack == wantAck) begin
      checkWord("ar", ar, mAr);
      checkWord("br", br, mBr);
      checkWord("mq", mq, mMq);
      checkWord("ebus", ebus, mEbus);
      checkWord("ad", ad, expAd);
      checkBit("adCarry", adCarry, expCarry);
      checkBit("adOverflow", adOverflow, expOvf);
      checkBit("ebusDrive", ebusDrive, mDrive);
      if (mFmValid[{fmBlock, fmAdr}]) begin
        checkWord("fm", fm, mFm[{fmBlock, fmAdr}]);
      end
      checksDone = checkRequests;
    end
  end

  task automatic setNopFields();
    adFunc       = eboxCramPkg::adAdd;
    adaSel       = eboxCramPkg::adaAr;
    adbSel       = eboxCramPkg::adbBr;
    arSel        = eboxCramPkg::arFromAd;
    arLeftLoad   = 1'b0;
    arRightLoad  = 1'b0;
    arLeftClr    = 1'b0;
    arRightClr   = 1'b0;
    brLoad       = 1'b0;
    mqOp         = eboxCramPkg::mqHold;
    fmBlock      = '0;
    fmAdr        = '0;
    fmWriteLeft  = 1'b0;
    fmWriteRight = 1'b0;
    ebusLeftEn   = 1'b0;
    ebusRightEn  = 1'b0;
  endtask

  task automatic drawDataWords();
    cacheData = drawBits(36);
    ebusIn    = drawBits(36);
    shiftIn   = drawBits(36);
    pc        = drawBits(36);
  endtask

  task automatic loadArFromCache();
    arSel       = eboxCramPkg::arFromCache;
    arLeftLoad  = 1'b1;
    arRightLoad = 1'b1;
  endtask

  // Four-phase step; req is held high for holdCycles after ack to stall the DUT
  task automatic runStep(input int holdCycles);
    int waited;
    int held;
    if (!hung) begin
      refStep();
      stepCount++;
      wantAck = 1'b1;
      checkRequests++;
      req = 1'b1;
      waited = 0;
      while (!ack && waited < stepTimeout) begin
        @(negedge eboxClk);
        waited++;
      end
      if (!ack) begin
        $display("Timeout: ack never rose after req at step %0d", stepCount);
        hung = 1'b1;
      end else begin
        for (held = 0; held < holdCycles; held++) begin
          @(negedge eboxClk);
          if (!ack) begin
            $display("Handshake error at %0t ns: ack fell while req was still high", $time);
            handshakeErrors++;
          end
        end
        req = 1'b0;
        waited = 0;
        while (ack && waited < stepTimeout) begin
          @(negedge eboxClk);
          waited++;
        end
        if (ack) begin
          $display("Timeout: ack stayed high after req dropped at step %0d", stepCount);
          hung = 1'b1;
        end else if (checksDone != checkRequests) begin
          $display("Outputs of step %0d were never compared while ack was high", stepCount);
          handshakeErrors++;
        end
      end
    end
  endtask

  task automatic reportTest(input string name, input int startErrors);
    int found;
    found = handshakeErrors + compareErrors - startErrors;
    if (hung) begin
      $display("%s: stopped by a timeout", name);
    end else if (found == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, found);
    end
  endtask

  task automatic resetState();
    int waited;
    wantAck = 1'b0;
    evalAd(expAd, expCarry, expOvf);
    checkRequests++;
    waited = 0;
    while (checksDone != checkRequests && waited < stepTimeout) begin
      @(negedge eboxClk);
      waited++;
    end
    if (checksDone != checkRequests) begin
      $display("Timeout: outputs were never compared after reset, ack may be stuck high");
      hung = 1'b1;
    end
    reportTest("reset state", 0);
  endtask

  task automatic fastMemoryTest();
    int startErrors;
    int n;
    startErrors = handshakeErrors + compareErrors;
    for (n = 0; n <= eboxWordPkg::fmDepth; n++) begin
      setNopFields();
      drawDataWords();
      loadArFromCache();
      // FM trails AR by one word
      if (n > 0) begin
        {fmBlock, fmAdr} = 7'(n - 1);
        fmWriteLeft      = 1'b1;
        fmWriteRight     = 1'b1;
      end
      runStep(0);
    end
    for (n = 0; n < 48; n++) begin
      setNopFields();
      drawDataWords();
      loadArFromCache();
      {fmBlock, fmAdr} = 7'(drawBits(7));
      fmWriteLeft      = 1'(drawBits(1));
      fmWriteRight     = 1'(drawBits(1));
      adbSel           = eboxCramPkg::adbFm;
      adFunc           = eboxCramPkg::adPassB;
      runStep(n % 2);
    end
    reportTest("fast memory halfwords", startErrors);
  endtask

  task automatic adderSweep();
    int startErrors;
    int n;
    startErrors = handshakeErrors + compareErrors;
    for (n = 0; n < 64; n++) begin
      setNopFields();
      drawDataWords();
      adFunc = 3'(n % 8);
      adaSel = 2'(drawBits(2));
      adbSel = 2'(drawBits(2));
      loadArFromCache();
      brLoad = 1'b1;
      mqOp   = eboxCramPkg::mqLoad;
      runStep(0);
    end
    reportTest("AD functions", startErrors);
  endtask

  task automatic arHalfwordSweep();
    int startErrors;
    int n;
    startErrors = handshakeErrors + compareErrors;
    for (n = 0; n < 64; n++) begin
      setNopFields();
      drawDataWords();
      adFunc = 3'(drawBits(3));
      adaSel = 2'(drawBits(2));
      adbSel = 2'(drawBits(2));
      arSel  = 2'(n / 16);
      {arLeftLoad, arRightLoad, arLeftClr, arRightClr} = 4'(n % 16);
      brLoad = 1'b1;
      runStep(n % 3);
    end
    reportTest("AR halfwords and BR", startErrors);
  endtask

  task automatic mqSequence();
    int startErrors;
    int n;
    startErrors = handshakeErrors + compareErrors;
    for (n = 0; n < 48; n++) begin
      setNopFields();
      drawDataWords();
      loadArFromCache();
      brLoad = 1'b1;
      // Add or subtract, so carries vary
      adFunc = 3'(drawBits(1));
      adaSel = 2'(drawBits(2));
      adbSel = 2'(drawBits(2));
      mqOp   = 2'(drawBits(2));
      runStep(0);
    end
    reportTest("MQ shift register", startErrors);
  endtask

  task automatic ebusEnables();
    int startErrors;
    int n;
    startErrors = handshakeErrors + compareErrors;
    for (n = 0; n < 16; n++) begin
      setNopFields();
      drawDataWords();
      adFunc = eboxCramPkg::adPassA;
      adaSel = eboxCramPkg::adaPc;
      {ebusLeftEn, ebusRightEn} = 2'(n % 4);
      runStep(n % 3);
    end
    reportTest("EBUS halves", startErrors);
  endtask

  initial begin
    int i;
    rstN      = 1'b0;
    req       = 1'b0;
    hung      = 1'b0;
    lfsrState = 32'd9;
    setNopFields();
    cacheData = '0;
    ebusIn    = '0;
    shiftIn   = '0;
    pc        = '0;
    mAr       = '0;
    mBr       = '0;
    mMq       = '0;
    mEbus     = '0;
    mDrive    = 1'b0;
    for (i = 0; i < eboxWordPkg::fmDepth; i++) begin
      mFm[i]      = '0;
      mFmValid[i] = 1'b0;
    end
    // Three full clock cycles of reset
    repeat (3) @(posedge eboxClk);
    @(negedge eboxClk);
    rstN = 1'b1;
    @(negedge eboxClk);
    resetState();
    fastMemoryTest();
    adderSweep();
    arHalfwordSweep();
    mqSequence();
    ebusEnables();
    $display("Summary: %0d steps, %0d checks, %0d errors", stepCount, checkCount,
             handshakeErrors + compareErrors);
    if (!hung && handshakeErrors == 0 && compareErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- eboxDataPath.f
eboxWordPkg.sv
eboxCramPkg.sv
microStepControl.sv
edpAdder.sv
edpRegisters.sv
fastMemory.sv
eboxDataPath.sv
eboxDataPathTb.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module eboxDataPathTb \
  -f eboxDataPath.f -o eboxDataPathSim

simOutput="$(./obj_dir/eboxDataPathSim)"
echo "$simOutput"

echo "$simOutput" | grep -q "SIMULATION PASSED"
